// File: hw/lsu_pkg.sv
// Shared widths, queue depths and the memory-operation encoding of the store path
// Every module of the load-store unit imports this package in its header

package lsu_pkg;

    // Datapath widths
    localparam int DATA_W     = 32;
    localparam int ADDR_W     = 32;
    localparam int TAG_W      = 6;

    // Queue and memory sizes
    localparam int SQ_DEPTH   = 8;
    localparam int LQ_DEPTH   = 8;
    localparam int MEM_WORDS  = 64;

    // Derived index widths
    localparam int SQ_IDX_W   = $clog2(SQ_DEPTH);
    localparam int WORD_IDX_W = $clog2(MEM_WORDS);
    localparam int BYTES_W    = DATA_W / 8;

    // Memory operation, stores first and then loads
    typedef enum logic [2:0] {
        SB,
        SH,
        SW,
        LB,
        LH,
        LW,
        LBU,
        LHU
    } lsu_func_t;

    // Byte lanes touched by an access of type func at byte offset addr_lo
    // Accesses are always naturally aligned
    function automatic logic [BYTES_W-1:0] byte_mask(lsu_func_t func, logic [1:0] addr_lo);
        logic [BYTES_W-1:0] mask;
        case (func)
            SB, LB, LBU: mask = 4'b0001 << addr_lo;
            // Half-word picks the low or high pair by address bit 1
            SH, LH, LHU: mask = addr_lo[1] ? 4'b1100 : 4'b0011;
            default:     mask = 4'b1111;
        endcase
        return mask;
    endfunction

endpackage

// File: hw/lsu_sq.sv
// Store queue of the load-store unit
// Issued stores wait here until the ROB retires them by tag, then the store is
// sent to the data memory and to the load queue in the same cycle

`timescale 1ns/100ps

module lsu_sq import lsu_pkg::*; (
    input  logic              clk,
    input  logic              n_rst,
    input  logic              i_flush,

    // Allocation of an issued store
    input  logic              i_alloc_en,
    input  logic [TAG_W-1:0]  i_alloc_tag,
    input  logic [ADDR_W-1:0] i_alloc_addr,
    input  logic [DATA_W-1:0] i_alloc_data,
    input  lsu_func_t         i_alloc_func,

    // Retirement request from the ROB
    input  logic              i_rob_retire_en,
    input  logic [TAG_W-1:0]  i_rob_retire_tag,
    input  logic              i_mem_stall,

    output logic              o_full,
    output logic              o_rob_retire_stall,

    // Retiring store towards memory and load queue
    output logic              o_retire_en,
    output logic [TAG_W-1:0]  o_retire_tag,
    output logic [ADDR_W-1:0] o_retire_addr,
    output logic [DATA_W-1:0] o_retire_data,
    output lsu_func_t         o_retire_func
);

    // Per-slot state, only valid is under reset
    logic [SQ_DEPTH-1:0] slot_valid;
    logic [TAG_W-1:0]    slot_tag  [SQ_DEPTH];
    logic [ADDR_W-1:0]   slot_addr [SQ_DEPTH];
    logic [DATA_W-1:0]   slot_data [SQ_DEPTH];
    lsu_func_t           slot_func [SQ_DEPTH];

    logic [SQ_DEPTH-1:0] empty;
    logic [SQ_DEPTH-1:0] alloc_sel;
    logic [SQ_DEPTH-1:0] retire_sel;
    logic [SQ_IDX_W-1:0] retire_idx;
    logic                allocating;
    logic                retiring;

    assign empty = ~slot_valid;

    // Lowest empty slot as a one-hot vector
    assign alloc_sel = empty & ~(empty - 1'b1);
    assign o_full    = ~|empty;

    // Allocation is dropped when full or flushing
    assign allocating = i_alloc_en & ~o_full & ~i_flush;

    // Tags are unique among valid slots so at most one bit is set
    always_comb begin
        for (int i = 0; i < SQ_DEPTH; i++) begin
            retire_sel[i] = slot_valid[i] && (slot_tag[i] == i_rob_retire_tag);
        end
    end

    // One-hot to binary slot number
    always_comb begin
        retire_idx = '0;
        for (int i = 0; i < SQ_DEPTH; i++) begin
            if (retire_sel[i]) begin
                retire_idx = retire_idx | SQ_IDX_W'(i);
            end
        end
    end

    // A cache miss with a full miss queue holds off the retirement
    assign o_rob_retire_stall = i_mem_stall;
    assign retiring           = i_rob_retire_en & ~i_mem_stall & |retire_sel;

    // The strobe only leaves when the store really goes to memory
    assign o_retire_en   = retiring;
    assign o_retire_tag  = slot_tag[retire_idx];
    assign o_retire_addr = slot_addr[retire_idx];
    assign o_retire_data = slot_data[retire_idx];
    assign o_retire_func = slot_func[retire_idx];

    // Flush wins over allocation, and the two selects never point at the same slot
    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            slot_valid <= '0;
        end else if (i_flush) begin
            slot_valid <= '0;
        end else begin
            for (int i = 0; i < SQ_DEPTH; i++) begin
                if (allocating && alloc_sel[i]) begin
                    slot_valid[i] <= 1'b1;
                end else if (retiring && retire_sel[i]) begin
                    slot_valid[i] <= 1'b0;
                end
            end
        end
    end

    // Store payload captured at allocation
    always_ff @(posedge clk) begin
        for (int i = 0; i < SQ_DEPTH; i++) begin
            if (allocating && alloc_sel[i]) begin
                slot_tag[i]  <= i_alloc_tag;
                slot_addr[i] <= i_alloc_addr;
                slot_data[i] <= i_alloc_data;
                slot_func[i] <= i_alloc_func;
            end
        end
    end

endmodule

// File: hw/lsu_lq.sv
// Load queue of the load-store unit
// Tracks speculatively executed loads and marks any load that a later retiring
// store overlaps, the mark is reported as a replay when the load retires

`timescale 1ns/100ps

module lsu_lq import lsu_pkg::*; (
    input  logic              clk,
    input  logic              n_rst,
    input  logic              i_flush,

    // Allocation of an executed load
    input  logic              i_alloc_en,
    input  logic [TAG_W-1:0]  i_alloc_tag,
    input  logic [ADDR_W-1:0] i_alloc_addr,
    input  lsu_func_t         i_alloc_func,

    // Store leaving the store queue
    input  logic              i_st_retire_en,
    input  logic [ADDR_W-1:0] i_st_retire_addr,
    input  lsu_func_t         i_st_retire_func,

    // Load retirement from the ROB
    input  logic              i_rob_retire_en,
    input  logic [TAG_W-1:0]  i_rob_retire_tag,

    output logic              o_full,
    output logic              o_replay
);

    // Per-slot load record
    logic [LQ_DEPTH-1:0] slot_valid;
    logic [TAG_W-1:0]    slot_tag   [LQ_DEPTH];
    logic [ADDR_W-3:0]   slot_waddr [LQ_DEPTH];
    logic [BYTES_W-1:0]  slot_mask  [LQ_DEPTH];
    logic [LQ_DEPTH-1:0] slot_flag;

    logic [LQ_DEPTH-1:0] empty;
    logic [LQ_DEPTH-1:0] alloc_sel;
    logic [LQ_DEPTH-1:0] retire_sel;
    logic [LQ_DEPTH-1:0] st_hit;
    logic [BYTES_W-1:0]  alloc_mask;
    logic [BYTES_W-1:0]  st_mask;
    logic                allocating;
    logic                retiring;

    assign empty     = ~slot_valid;
    assign alloc_sel = empty & ~(empty - 1'b1);
    assign o_full    = ~|empty;

    assign allocating = i_alloc_en & ~o_full & ~i_flush;
    assign alloc_mask = byte_mask(i_alloc_func, i_alloc_addr[1:0])
    ;
    assign st_mask    = byte_mask(i_st_retire_func, i_st_retire_addr[1:0]);

    // Every queued load is younger than a retiring store, so an overlap means
    // the load read stale data
    always_comb begin
        for (int i = 0; i < LQ_DEPTH; i++) begin
            st_hit[i]     = i_st_retire_en && slot_valid[i] &&
                            (slot_waddr[i] == i_st_retire_addr[ADDR_W-1:2]) &&
                            |(slot_mask[i] & st_mask);
            retire_sel[i] = slot_valid[i] && (slot_tag[i] == i_rob_retire_tag);
        end
    end

    assign retiring = i_rob_retire_en & |retire_sel;

    // Replay goes out in the retirement cycle itself
    assign o_replay = retiring & |(retire_sel & slot_flag);

    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            slot_valid <= '0;
        end else if (i_flush) begin
            slot_valid <= '0;
        end else begin
            for (int i = 0; i < LQ_DEPTH; i++) begin
                if (allocating && alloc_sel[i]) begin
                    slot_valid[i] <= 1'b1;
                end else if (retiring && retire_sel[i]) begin
                    slot_valid[i] <= 1'b0;
                end
            end
        end
    end

    // A new load starts clean, a hit only ever sets the flag
    always_ff @(posedge clk) begin
        for (int i = 0; i < LQ_DEPTH; i++) begin
            if (allocating && alloc_sel[i]) begin
                slot_tag[i]   <= i_alloc_tag;
                slot_waddr[i] <= i_alloc_addr[ADDR_W-1:2];
                slot_mask[i]  <= alloc_mask;
                slot_flag[i]  <= 1'b0;
            end else if (st_hit[i]) begin
                slot_flag[i]  <= 1'b1;
            end
        end
    end

endmodule

// File: hw/lsu_dmem.sv
// Word-addressed data memory behind the store queue
// Retiring stores write their byte lanes, and one read port returns a word
// one cycle after the address is presented

`timescale 1ns/100ps

module lsu_dmem import lsu_pkg::*; (
    input  logic              clk,

    // Write port fed by the retiring store
    input  logic              i_wr_en,
    input  logic [ADDR_W-1:0] i_wr_addr,
    input  logic [DATA_W-1:0] i_wr_data,
    input  lsu_func_t         i_wr_func,

    // Registered read port
    input  logic [ADDR_W-1:0] i_rd_addr,
    output logic [DATA_W-1:0] o_rd_data
);

    logic [DATA_W-1:0]     mem [MEM_WORDS];

    logic [WORD_IDX_W-1:0] wr_idx;
    logic [WORD_IDX_W-1:0] rd_idx;
    logic [BYTES_W-1:0]    wr_mask;
    logic [DATA_W-1:0]     wr_lanes;

    // Bits 7 to 2 pick the word, anything above wraps
    assign wr_idx = i_wr_addr[WORD_IDX_W+1:2];
    assign rd_idx = i_rd_addr[WORD_IDX_W+1:2];

    // Move a byte or half-word up to the lane its offset names
    assign wr_lanes = i_wr_data << {i_wr_addr[1:0], 3'b000};
    assign wr_mask  = byte_mask(i_wr_func, i_wr_addr[1:0]);

    initial begin
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (i_wr_en) begin
            for (int b = 0; b < BYTES_W; b++) begin
                if (wr_mask[b]) begin
                    mem[wr_idx][8*b +: 8] <= wr_lanes[8*b +: 8];
                end
            end
        end
    end

    // A write at the same edge shows up on the following read
    always_ff @(posedge clk) begin
        o_rd_data <= mem[rd_idx];
    end

endmodule

// File: hw/lsu_store_path.sv
// Store side of the load-store unit
// Joins the store queue, the load queue and the data memory through one
// retiring-store bundle

`timescale 1ns/100ps

module lsu_store_path import lsu_pkg::*; (
    input  logic              clk,
    input  logic              n_rst,
    input  logic              i_flush,

    // Store allocation and retirement
    input  logic              i_st_alloc_en,
    input  logic [TAG_W-1:0]  i_st_alloc_tag,
    input  logic [ADDR_W-1:0] i_st_alloc_addr,
    input  logic [DATA_W-1:0] i_st_alloc_data,
    input  lsu_func_t         i_st_alloc_func,
    input  logic              i_rob_st_retire_en,
    input  logic [TAG_W-1:0]  i_rob_st_retire_tag,
    input  logic              i_mem_stall,

    // Load allocation and retirement
    input  logic              i_ld_alloc_en,
    input  logic [TAG_W-1:0]  i_ld_alloc_tag,
    input  logic [ADDR_W-1:0] i_ld_alloc_addr,
    input  lsu_func_t         i_ld_alloc_func,
    input  logic              i_rob_ld_retire_en,
    input  logic [TAG_W-1:0]  i_rob_ld_retire_tag,

    input  logic [ADDR_W-1:0] i_mem_rd_addr,

    output logic              o_sq_full,
    output logic              o_lq_full,
    output logic              o_rob_st_retire_stall,
    output logic              o_st_retire_en,
    output logic [TAG_W-1:0]  o_st_retire_tag,
    output logic              o_ld_replay,
    output logic [DATA_W-1:0] o_mem_rd_data
);

    // Retiring store shared by memory and load queue
    logic              sq_retire_en;
    logic [TAG_W-1:0]  sq_retire_tag;
    logic [ADDR_W-1:0] sq_retire_addr;
    logic [DATA_W-1:0] sq_retire_data;
    lsu_func_t         sq_retire_func;

    assign o_st_retire_en  = sq_retire_en;
    assign o_st_retire_tag = sq_retire_tag;

    lsu_sq i_lsu_sq (
        .clk                (clk),
        .n_rst              (n_rst),
        .i_flush            (i_flush),
        .i_alloc_en         (i_st_alloc_en),
        .i_alloc_tag        (i_st_alloc_tag),
        .i_alloc_addr       (i_st_alloc_addr),
        .i_alloc_data       (i_st_alloc_data),
        .i_alloc_func       (i_st_alloc_func),
        .i_rob_retire_en    (i_rob_st_retire_en),
        .i_rob_retire_tag   (i_rob_st_retire_tag),
        .i_mem_stall        (i_mem_stall),
        .o_full             (o_sq_full),
        .o_rob_retire_stall (o_rob_st_retire_stall),
        .o_retire_en        (sq_retire_en),
        .o_retire_tag       (sq_retire_tag),
        .o_retire_addr      (sq_retire_addr),
        .o_retire_data      (sq_retire_data),
        .o_retire_func      (sq_retire_func)
    );

    lsu_lq i_lsu_lq (
        .clk              (clk),
        .n_rst            (n_rst),
        .i_flush          (i_flush),
        .i_alloc_en       (i_ld_alloc_en),
        .i_alloc_tag      (i_ld_alloc_tag),
        .i_alloc_addr     (i_ld_alloc_addr),
        .i_alloc_func     (i_ld_alloc_func),
        .i_st_retire_en   (sq_retire_en),
        .i_st_retire_addr (sq_retire_addr),
        .i_st_retire_func (sq_retire_func),
        .i_rob_retire_en  (i_rob_ld_retire_en),
        .i_rob_retire_tag (i_rob_ld_retire_tag),
        .o_full           (o_lq_full),
        .o_replay         (o_ld_replay)
    );

    lsu_dmem i_lsu_dmem (
        .clk       (clk),
        .i_wr_en   (sq_retire_en),
        .i_wr_addr (sq_retire_addr),
        .i_wr_data (sq_retire_data),
        .i_wr_func (sq_retire_func),
        .i_rd_addr (i_mem_rd_addr),
        .o_rd_data (o_mem_rd_data)
    );

endmodule

// File: sim/lsu_store_path_checker.sv
// Assertions on the store queue handshake and occupancy
// Bound into every lsu_sq instance at the end of this file

`timescale 1ns/100ps

module lsu_store_path_checker import lsu_pkg::*; (
    input logic                clk,
    input logic                n_rst,
    input logic                i_flush,
    input logic                i_alloc_en,
    input logic                i_mem_stall,
    input logic                o_full,
    input logic                o_retire_en,
    input logic [SQ_DEPTH-1:0] slot_valid
);

    // Number of broken rules so far
    int fail_cnt = 0;

    // A flush clears every slot so full cannot survive it
    assert property (@(posedge clk) disable iff (!n_rst) i_flush |=> !o_full) else begin
        fail_cnt++;
        $error("store queue still full after a flush");
    end

    // A stalled memory takes no store
    assert property (@(posedge clk) disable iff (!n_rst) i_mem_stall |-> !o_retire_en) else begin
        fail_cnt++;
        $error("store retired while the memory stalled");
    end

    // With the queue full and nothing leaving, an allocation must not touch any slot
    assert property (@(posedge clk) disable iff (!n_rst)
        (o_full && i_alloc_en && !o_retire_en && !i_flush) |=>
        (slot_valid == $past(slot_valid))) else begin
        fail_cnt++;
        $error("allocation accepted while the store queue was full");
    end

endmodule

bind lsu_sq lsu_store_path_checker i_sq_checker (
    .clk         (clk),
    .n_rst       (n_rst),
    .i_flush     (i_flush),
    .i_alloc_en  (i_alloc_en),
    .i_mem_stall (i_mem_stall),
    .o_full      (o_full),
    .o_retire_en (o_retire_en),
    .slot_valid  (slot_valid)
);

// File: sim/lsu_store_path_tb.sv
// Testbench for the store path of the load-store unit
// Random stores and loads are allocated and retired in program order against a
// model of both queues and the data memory, and one result line closes the run

`timescale 1ns/100ps

module lsu_store_path_tb import lsu_pkg::*; ();

    localparam int          N_OPS      = 1500;
    // Reset, the stimulus slots and a drain of at most 16 entries, with margin
    localparam int          MAX_CYCLES = 2 * N_OPS + 1000;
    localparam logic [31:0] LFSR_TAPS  = 32'h80200003;

    typedef struct packed {
        logic             is_st;
        logic [TAG_W-1:0] tag;
        logic [31:0]      addr;
        logic [31:0]      data;
        lsu_func_t        func;
        logic             flag;
    } op_t;

    logic              clk = 1'b0;
    logic              n_rst;
    logic              i_flush;
    logic              i_mem_stall;
    logic              i_st_alloc_en;
    logic              i_ld_alloc_en;
    logic              i_rob_st_retire_en;
    logic              i_rob_ld_retire_en;
    logic [TAG_W-1:0]  i_st_alloc_tag;
    logic [TAG_W-1:0]  i_ld_alloc_tag;
    logic [TAG_W-1:0]  i_rob_st_retire_tag;
    logic [TAG_W-1:0]  i_rob_ld_retire_tag;
    logic [ADDR_W-1:0] i_st_alloc_addr;
    logic [ADDR_W-1:0] i_ld_alloc_addr;
    logic [ADDR_W-1:0] i_mem_rd_addr;
    logic [DATA_W-1:0] i_st_alloc_data;
    lsu_func_t         i_st_alloc_func;
    lsu_func_t         i_ld_alloc_func;
    logic              o_sq_full;
    logic              o_lq_full;
    logic              o_rob_st_retire_stall;
    logic              o_st_retire_en;
    logic [TAG_W-1:0]  o_st_retire_tag;
    logic              o_ld_replay;
    logic [DATA_W-1:0] o_mem_rd_data;

    // Program-order list of allocated operations that have not retired
    op_t               pend [$];
    logic [31:0]       model_mem [MEM_WORDS];
    logic [31:0]       lfsr = 32'ha511f0c6;
    logic [TAG_W-1:0]  next_tag = '0;
    int                sq_cnt = 0;
    int                lq_cnt = 0;
    int                cycle_cnt = 0;
    int                err_full = 0;
    int                err_retire = 0;
    int                err_mem = 0;
    int                err_replay = 0;

    // Memory read-back goes request, address driven, compared
    logic              req_v = 1'b0;
    logic              chk_v = 1'b0;
    logic              cmp_v = 1'b0;
    logic [5:0]        req_word = '0;
    logic [31:0]       chk_exp;
    logic [31:0]       cmp_exp;

    lsu_store_path i_lsu_store_path (.*);

    always #5 clk = ~clk;

    // Hard stop in case a wait never ends
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("Timeout after %0d cycles, the run did not finish", MAX_CYCLES);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    // Galois LFSR stepped once for every bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ LFSR_TAPS) : (lfsr >> 1);
        end
        return v;
    endfunction

    // Byte lanes of an aligned access
    function automatic logic [3:0] lanes_of(lsu_func_t f, logic [1:0] lo);
        logic [3:0] m;
        if (f == SW || f == LW) begin
            m = 4'hf;
        end else if (f == SH || f == LH || f == LHU) begin
            m = lo[1] ? 4'hc : 4'h3;
        end else begin
            m = 4'h1 << lo;
        end
        return m;
    endfunction

    // Random aligned access to words 4 to 7, a narrow window so that overlaps are common
    function automatic op_t new_op();
        op_t        op;
        logic [1:0] size;
        logic [1:0] lo;
        op.is_st = 1'(rand_bits(1));
        op.tag   = next_tag;
        op.data  = rand_bits(32);
        op.flag  = 1'b0;
        size     = 2'(rand_bits(2) % 3);
        lo       = 2'(rand_bits(2));
        // Halves sit on even bytes and words on byte 0
        if (size == 2'd1) begin
            lo[0] = 1'b0;
        end else if (size == 2'd2) begin
            lo = 2'b00;
        end
        case (size)
            2'd0:    op.func = op.is_st ? SB : (rand_bits(1) ? LBU : LB);
            2'd1:    op.func = op.is_st ? SH : (rand_bits(1) ? LHU : LH);
            default: op.func = op.is_st ? SW : LW;
        endcase
        op.addr  = {26'h0, 2'b01, 2'(rand_bits(2)), lo};
        return op;
    endfunction

    // Merge a retiring store into the model memory and flag the queued loads it overlaps
    task automatic apply_store(input op_t st);
        logic [3:0]  st_m;
        logic [31:0] lanes;
        op_t         ld;
        st_m  = lanes_of(st.func, st.addr[1:0]);
        lanes = st.data << (8 * st.addr[1:0]);
        for (int b = 0; b < 4; b++) begin
            if (st_m[b]) model_mem[st.addr[7:2]][8*b +: 8] = lanes[8*b +: 8];
        end
        // Every load still listed is younger than this store
        for (int i = 0; i < pend.size(); i++) begin
            ld = pend[i];
            if (!ld.is_st && ld.addr[31:2] == st.addr[31:2] &&
                (lanes_of(ld.func, ld.addr[1:0]) & st_m) != 4'h0) begin
                ld.flag = 1'b1;
                pend[i] = ld;
            end
        end
    endtask

    // One clock of stimulus, checks at the falling edge, then the model update
    task automatic run_cycle(input bit drain);
        op_t op;
        op_t old;
        bit  stall;
        bit  do_flush;
        bit  do_alloc;
        bit  do_ret;
        bit  st_acc;
        bit  ld_acc;
        bit  st_ok;
        bit  ld_ok;
        int  thr;
        @(posedge clk);
        cmp_v   = chk_v;
        cmp_exp = chk_exp;
        chk_v   = req_v;
        chk_exp = model_mem[req_word];
        i_mem_rd_addr <= ADDR_W'({req_word, 2'b00});
        req_v   = 1'b0;
        // Phases of 64 cycles alternate between filling and draining the queues
        thr      = cycle_cnt[6] ? 7 : 3;
        op       = new_op();
        stall    = !drain && (rand_bits(2) == 0);
        do_flush = !drain && (rand_bits(7) == 0);
        do_alloc = !drain && !do_flush && (rand_bits(3) < thr);
        do_ret   = !do_flush && (pend.size() > 0) && (drain || rand_bits(3) < 10 - thr);
        old      = (pend.size() > 0) ? pend[0] : op;
        // Acceptance depends on the occupancy before this edge
        st_acc   = do_alloc && op.is_st && (sq_cnt < SQ_DEPTH);
        ld_acc   = do_alloc && !op.is_st && (lq_cnt < LQ_DEPTH);
        st_ok    = do_ret && old.is_st && !stall;
        ld_ok    = do_ret && !old.is_st;
        i_flush             <= do_flush;
        i_mem_stall         <= stall;
        i_st_alloc_en       <= do_alloc && op.is_st;
        i_ld_alloc_en       <= do_alloc && !op.is_st;
        i_st_alloc_tag      <= op.tag;
        i_ld_alloc_tag      <= op.tag;
        i_st_alloc_addr     <= op.addr;
        i_ld_alloc_addr     <= op.addr;
        i_st_alloc_data     <= op.data;
        i_st_alloc_func     <= op.func;
        i_ld_alloc_func     <= op.func;
        i_rob_st_retire_en  <= do_ret && old.is_st;
        i_rob_ld_retire_en  <= do_ret && !old.is_st;
        i_rob_st_retire_tag <= old.tag;
        i_rob_ld_retire_tag <= old.tag;

        @(negedge clk);
        if (cmp_v) begin
            assert (o_mem_rd_data == cmp_exp) else begin
                err_mem++;
                $display("[ERROR] o_mem_rd_data: got %h, expected %h", o_mem_rd_data, cmp_exp);
            end
        end
        assert (o_sq_full == (sq_cnt == SQ_DEPTH)) else begin
            err_full++;
            $display("[ERROR] o_sq_full: got %h, expected %h", o_sq_full, sq_cnt == SQ_DEPTH);
        end
        assert (o_lq_full == (lq_cnt == LQ_DEPTH)) else begin
            err_full++;
            $display("[ERROR] o_lq_full: got %h, expected %h", o_lq_full, lq_cnt == LQ_DEPTH);
        end
        assert (o_rob_st_retire_stall == stall) else begin
            err_retire++;
            $display("[ERROR] o_rob_st_retire_stall: got %h, expected %h",
                     o_rob_st_retire_stall, stall);
        end
        assert (o_st_retire_en == st_ok) else begin
            err_retire++;
            $display("[ERROR] o_st_retire_en: got %h, expected %h", o_st_retire_en, st_ok);
        end
        if (st_ok) begin
            assert (o_st_retire_tag == old.tag) else begin
                err_retire++;
                $display("[ERROR] o_st_retire_tag: got %h, expected %h", o_st_retire_tag, old.tag);
            end
        end
        assert (o_ld_replay == (ld_ok && old.flag)) else begin
            err_replay++;
            $display("[ERROR] o_ld_replay: got %h, expected %h", o_ld_replay, ld_ok && old.flag);
        end

        if (do_flush) begin
            pend.delete();
            sq_cnt = 0;
            lq_cnt = 0;
        end
        if (st_ok) begin
            apply_store(old);
            void'(pend.pop_front());
            sq_cnt--;
            req_v    = 1'b1;
            req_word = old.addr[7:2];
        end
        if (ld_ok) begin
            void'(pend.pop_front());
            lq_cnt--;
        end
        // A load allocated at the edge of a store retirement is not flagged by it
        if (st_acc || ld_acc) begin
            pend.push_back(op);
            next_tag++;
            if (st_acc) sq_cnt++;
            else lq_cnt++;
        end
    endtask

    initial begin
        int n_chk;
        n_rst               = 1'b0;
        i_flush             = 1'b0;
        i_mem_stall         = 1'b0;
        i_st_alloc_en       = 1'b0;
        i_ld_alloc_en       = 1'b0;
        i_rob_st_retire_en  = 1'b0;
        i_rob_ld_retire_en  = 1'b0;
        i_st_alloc_tag      = '0;
        i_ld_alloc_tag      = '0;
        i_rob_st_retire_tag = '0;
        i_rob_ld_retire_tag = '0;
        i_st_alloc_addr     = '0;
        i_ld_alloc_addr     = '0;
        i_mem_rd_addr       = '0;
        i_st_alloc_data     = '0;
        i_st_alloc_func     = SB;
        i_ld_alloc_func     = LB;
        for (int i = 0; i < MEM_WORDS; i++) begin
            model_mem[i] = '0;
        end
        repeat (16) @(posedge clk);
        n_rst <= 1'b1;
        for (int k = 0; k < N_OPS; k++) begin
            run_cycle(1'b0);
        end
        // Retire what is left unstalled, then let the last read-backs complete
        while (pend.size() > 0) begin
            run_cycle(1'b1);
        end
        repeat (3) run_cycle(1'b1);
        n_chk = i_lsu_store_path.i_lsu_sq.i_sq_checker.fail_cnt;
        $display("Error counts: full %0d, retire %0d, memory %0d, replay %0d, checker %0d",
                 err_full, err_retire, err_mem, err_replay, n_chk);
        if (err_full + err_retire + err_mem + err_replay + n_chk == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: flist.f
hw/lsu_pkg.sv
hw/lsu_sq.sv
hw/lsu_lq.sv
hw/lsu_dmem.sv
hw/lsu_store_path.sv
sim/lsu_store_path_checker.sv
sim/lsu_store_path_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = lsu_store_path_tb
FLIST     = flist.f
BUILD     = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FLIST)
	./$(BUILD)/V$(TOP) +verilator+error+limit+100 | tee $(LOG)
	grep -q "RESULT: PASS" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
